/* decodePkg.sv */
// Decode stage shared types: opcodes, ALU codes and control-word layout
package decodePkg;

    // Data path and register select widths
    localparam int DataWidth = 16;
    localparam int RegSelWidth = 3;

    // Opcodes from instruction bits 15:11
    localparam logic [4:0] HALT  = 5'b00000;
    localparam logic [4:0] NOP   = 5'b00001;
    localparam logic [4:0] J     = 5'b00100;
    localparam logic [4:0] JAL   = 5'b00110;
    localparam logic [4:0] ADDI  = 5'b01000;
    localparam logic [4:0] SUBI  = 5'b01001;
    localparam logic [4:0] XORI  = 5'b01010;
    localparam logic [4:0] ANDNI = 5'b01011;
    localparam logic [4:0] BEQZ  = 5'b01100;
    localparam logic [4:0] BNEZ  = 5'b01101;
    localparam logic [4:0] ST    = 5'b10000;
    localparam logic [4:0] LD    = 5'b10001;
    localparam logic [4:0] LBI   = 5'b11000;
    localparam logic [4:0] RTYPE = 5'b11011;
    localparam logic [4:0] SEQ   = 5'b11100;

    // Which instruction field names the destination
    typedef enum logic [1:0] {ITYPE, RTYPE_RD, RS_FIELD, LINK} regDstSel;

    typedef enum logic [3:0] {ADD, XOR, ANDN, PASSB, EQ} aluOpT;

    // FUNC takes the operation from instruction bits 1:0
    typedef enum logic [2:0] {ADD_I, SUB_I, XOR_I, ANDN_I, PASS_B, CMP_EQ, FUNC} aluClassT;

    // One hot, all zero when no control transfer
    typedef enum logic [3:0] {
        BR_NONE = 4'b0000,
        BR_EQZ  = 4'b0001,
        BR_NEZ  = 4'b0010,
        BR_JMP  = 4'b0100
    } branchT;

    typedef enum logic [1:0] {BSRC_RT, BSRC_IMM5, BSRC_IMM8, BSRC_SIMM11} bSrcT;

    typedef enum logic [1:0] {RSRC_ALU, RSRC_MEM, RSRC_LINK, RSRC_IMM} regSrcT;

    // Control word handed to execute
    typedef struct packed {
        logic     regWrt;
        regDstSel regDst;
        logic     zeroExt;
        logic     memRead;
        logic     memWrt;
        logic     immSrc;
        bSrcT     bSrc;
        regSrcT   regSrc;
        logic     aluSign;
        logic     aluJmp;
        branchT   branch;
        aluClassT aluClass;
    } ctrlWordT;

    typedef struct packed {
        aluOpT oper;
        logic  invA;
        logic  invB;
        logic  cin;
    } aluCtrlT;

endpackage

/* regPortIf.sv */
// Register file access port between the decode stage and the register file
interface regPortIf
    import decodePkg::*;
();

    // Two read ports, combinational
    logic [RegSelWidth-1:0] read1Sel;
    logic [RegSelWidth-1:0] read2Sel;
    logic [DataWidth-1:0]   read1Data;
    logic [DataWidth-1:0]   read2Data;

    // Writeback port, committed at the clock edge
    logic [RegSelWidth-1:0] writeSel;
    logic                   writeEn;
    logic [DataWidth-1:0]   writeData;

    modport stage (
        output read1Sel,
        output read2Sel,
        output writeSel,
        output writeEn,
        output writeData,
        input  read1Data,
        input  read2Data
    );

    modport file (
        input  read1Sel,
        input  read2Sel,
        input  writeSel,
        input  writeEn,
        input  writeData,
        output read1Data,
        output read2Data
    );

endinterface

/* controlDecoder.sv */
// Main decoder: maps the opcode to the execute control word, flags halt and illegal opcodes
module controlDecoder
    import decodePkg::*;
(
    input  logic [15:0] instr,
    output ctrlWordT    ctrl,
    output logic        halt,
    output logic        err
);

    logic [4:0] opcode;

    assign opcode = instr[15:11];

    always_comb begin
        // Quiet word: no write, no memory, no branch
        ctrl = '0;
        halt = 1'b0;
        err = 1'b0;

        case (opcode)
            HALT: begin
                halt = 1'b1;
            end
            NOP: begin
                ctrl.aluClass = ADD_I;
            end
            J: begin
                ctrl.aluJmp = 1'b1;
                ctrl.immSrc = 1'b1;
                ctrl.bSrc = BSRC_SIMM11;
                ctrl.branch = BR_JMP;
                ctrl.aluClass = ADD_I;
            end
            JAL: begin
                // Target as for J, plus link into r7
                ctrl.aluJmp = 1'b1;
                ctrl.immSrc = 1'b1;
                ctrl.bSrc = BSRC_SIMM11;
                ctrl.branch = BR_JMP;
                ctrl.aluClass = ADD_I;
                ctrl.regWrt = 1'b1;
                ctrl.regDst = LINK;
                ctrl.regSrc = RSRC_LINK;
            end
            ADDI, SUBI, XORI, ANDNI: begin
                ctrl.regWrt = 1'b1;
                ctrl.regDst = ITYPE;
                ctrl.immSrc = 1'b1;
                ctrl.bSrc = BSRC_IMM5;
                ctrl.regSrc = RSRC_ALU;
                // Logical immediates extend with zeros
                ctrl.zeroExt = (opcode == XORI) || (opcode == ANDNI);
                ctrl.aluSign = (opcode == ADDI) || (opcode == SUBI);
                case (opcode)
                    ADDI:    ctrl.aluClass = ADD_I;
                    SUBI:    ctrl.aluClass = SUB_I;
                    XORI:    ctrl.aluClass = XOR_I;
                    default: ctrl.aluClass = ANDN_I;
                endcase
            end
            BEQZ, BNEZ: begin
                // Condition is tested on Rs, offset is the 8-bit immediate
                ctrl.bSrc = BSRC_IMM8;
                ctrl.aluSign = 1'b1;
                ctrl.aluClass = PASS_B;
                ctrl.branch = (opcode == BEQZ) ? BR_EQZ : BR_NEZ;
            end
            ST: begin
                ctrl.memWrt = 1'b1;
                ctrl.immSrc = 1'b1;
                ctrl.bSrc = BSRC_IMM5;
                ctrl.aluClass = ADD_I;
            end
            LD: begin
                ctrl.memRead = 1'b1;
                ctrl.regWrt = 1'b1;
                ctrl.regDst = ITYPE;
                ctrl.immSrc = 1'b1;
                ctrl.bSrc = BSRC_IMM5;
                ctrl.regSrc = RSRC_MEM;
                ctrl.aluClass = ADD_I;
            end
            LBI: begin
                ctrl.regWrt = 1'b1;
                ctrl.regDst = RS_FIELD;
                ctrl.immSrc = 1'b1;
                ctrl.bSrc = BSRC_IMM8;
                ctrl.regSrc = RSRC_IMM;
                ctrl.aluClass = PASS_B;
            end
            RTYPE: begin
                ctrl.regWrt = 1'b1;
                ctrl.regDst = RTYPE_RD;
                ctrl.bSrc = BSRC_RT;
                ctrl.regSrc = RSRC_ALU;
                ctrl.aluSign = 1'b1;
                ctrl.aluClass = FUNC;
            end
            SEQ: begin
                ctrl.regWrt = 1'b1;
                ctrl.regDst = RTYPE_RD;
                ctrl.bSrc = BSRC_RT;
                ctrl.regSrc = RSRC_ALU;
                ctrl.aluSign = 1'b1;
                ctrl.aluClass = CMP_EQ;
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

endmodule

/* aluControl.sv */
// ALU operation decoder: class and function bits to operation, inversions and carry-in
module aluControl
    import decodePkg::*;
(
    input  aluClassT   aluClass,
    input  logic [1:0] func,
    output aluCtrlT    aluCtrl
);

    aluClassT effClass;

    // R-type function bits reuse the I-type classes
    always_comb begin
        if (aluClass == FUNC) begin
            case (func)
                2'b00:   effClass = ADD_I;
                2'b01:   effClass = SUB_I;
                2'b10:   effClass = XOR_I;
                default: effClass = ANDN_I;
            endcase
        end else begin
            effClass = aluClass;
        end
    end

    always_comb begin
        aluCtrl = '0;
        case (effClass)
            ADD_I: begin
                aluCtrl.oper = ADD;
            end
            SUB_I: begin
                // Subtract as ~A + B + 1
                aluCtrl.oper = ADD;
                aluCtrl.invA = 1'b1;
                aluCtrl.cin = 1'b1;
            end
            XOR_I: begin
                aluCtrl.oper = XOR;
            end
            ANDN_I: begin
                aluCtrl.oper = ANDN;
                aluCtrl.invB = 1'b1;
            end
            CMP_EQ: begin
                // Equal when the difference is zero
                aluCtrl.oper = EQ;
                aluCtrl.invA = 1'b1;
                aluCtrl.cin = 1'b1;
            end
            default: begin
                aluCtrl.oper = PASSB;
            end
        endcase
    end

endmodule

/* regFile.sv */
// Eight-entry register file with two bypassed read ports and one write port
module regFile
    import decodePkg::*;
(
    input logic     clk,
    input logic     reset,
    regPortIf.file  port
);

    localparam int NumRegs = 1 << RegSelWidth;

    logic [DataWidth-1:0] regs [NumRegs];

    // A read of the register being written sees the new value
    function automatic logic [DataWidth-1:0] readPort(
        input logic [RegSelWidth-1:0] sel
    );
        logic [DataWidth-1:0] value;
        value = regs[sel];
        if (port.writeEn && (port.writeSel == sel)) begin
            value = port.writeData;
        end
        return value;
    endfunction

    always_comb begin
        port.read1Data = readPort(port.read1Sel);
        port.read2Data = readPort(port.read2Sel);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (port.writeEn) begin
            regs[port.writeSel] <= port.writeData;
        end
    end

    // Writeback must always name a real register
    writeSelKnown: assert property (
        @(posedge clk) disable iff (reset)
        port.writeEn |-> !$isunknown(port.writeSel)
    ) else $error("write enabled with unknown writeSel");

endmodule

/* decodeStage.sv */
// Instruction decode stage: control decode, register read, immediates and ID/EX registers
module decodeStage
    import decodePkg::*;
#(
    parameter int WbLatency = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [15:0]            instr,
    input  logic [DataWidth-1:0]   pc,
    input  logic [DataWidth-1:0]   wbData,

    output logic                   regWrt,
    output logic                   memRead,
    output logic                   memWrt,
    output logic                   immSrc,
    output logic [1:0]             bSrc,
    output logic [1:0]             regSrc,
    output logic                   aluSign,
    output logic                   aluJmp,
    output logic [3:0]             branch,

    output logic [3:0]             oper,
    output logic                   invA,
    output logic                   invB,
    output logic                   cin,

    output logic [DataWidth-1:0]   rsData,
    output logic [DataWidth-1:0]   rtData,
    output logic [DataWidth-1:0]   imm5,
    output logic [DataWidth-1:0]   imm8,
    output logic [DataWidth-1:0]   sImm8,
    output logic [DataWidth-1:0]   sImm11,
    output logic [DataWidth-1:0]   pcNext,
    output logic [RegSelWidth-1:0] rd,
    output logic                   halt,
    output logic                   err
);

    ctrlWordT               ctrl;
    aluCtrlT                aluCtrl;
    logic                   haltDec;
    logic                   errDec;
    logic [RegSelWidth-1:0] dstSel;
    logic [DataWidth-1:0]   imm5Ext;
    logic [DataWidth-1:0]   imm8Ext;
    logic [DataWidth-1:0]   sImm8Ext;
    logic [DataWidth-1:0]   sImm11Ext;

    // Destination and write enable waiting for their writeback data
    logic [RegSelWidth-1:0] wbSelPipe [WbLatency];
    logic                   wbEnPipe [WbLatency];

    regPortIf regPort ();

    controlDecoder controlDecoder_i (
        .instr (instr),
        .ctrl  (ctrl),
        .halt  (haltDec),
        .err   (errDec)
    );

    aluControl aluControl_i (
        .aluClass (ctrl.aluClass),
        .func     (instr[1:0]),
        .aluCtrl  (aluCtrl)
    );

    regFile regFile_i (
        .clk   (clk),
        .reset (reset),
        .port  (regPort.file)
    );

    // Rs and Rt fields feed the read ports
    assign regPort.read1Sel = instr[10:8];
    assign regPort.read2Sel = instr[7:5];
    assign regPort.writeSel = wbSelPipe[WbLatency-1];
    assign regPort.writeEn = wbEnPipe[WbLatency-1];
    assign regPort.writeData = wbData;

    always_comb begin
        case (ctrl.regDst)
            ITYPE:    dstSel = instr[7:5];
            RTYPE_RD: dstSel = instr[4:2];
            RS_FIELD: dstSel = instr[10:8];
            default:  dstSel = '1;
        endcase
    end

    // Immediate extension
    assign sImm8Ext = {{(DataWidth-8){instr[7]}}, instr[7:0]};
    assign sImm11Ext = {{(DataWidth-11){instr[10]}}, instr[10:0]};
    assign imm5Ext = ctrl.zeroExt ? {{(DataWidth-5){1'b0}}, instr[4:0]}
                                  : {{(DataWidth-5){instr[4]}}, instr[4:0]};
    assign imm8Ext = ctrl.zeroExt ? {{(DataWidth-8){1'b0}}, instr[7:0]} : sImm8Ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < WbLatency; i++) begin
                wbSelPipe[i] <= '0;
                wbEnPipe[i] <= 1'b0;
            end
        end else begin
            wbSelPipe[0] <= dstSel;
            wbEnPipe[0] <= ctrl.regWrt;
            for (int i = 1; i < WbLatency; i++) begin
                wbSelPipe[i] <= wbSelPipe[i-1];
                wbEnPipe[i] <= wbEnPipe[i-1];
            end
        end
    end

    // ID/EX boundary
    always_ff @(posedge clk) begin
        if (reset) begin
            regWrt <= 1'b0;
            memRead <= 1'b0;
            memWrt <= 1'b0;
            immSrc <= 1'b0;
            bSrc <= '0;
            regSrc <= '0;
            aluSign <= 1'b0;
            aluJmp <= 1'b0;
            branch <= '0;
            oper <= '0;
            invA <= 1'b0;
            invB <= 1'b0;
            cin <= 1'b0;
            rsData <= '0;
            rtData <= '0;
            imm5 <= '0;
            imm8 <= '0;
            sImm8 <= '0;
            sImm11 <= '0;
            pcNext <= '0;
            rd <= '0;
            halt <= 1'b0;
            err <= 1'b0;
        end else begin
            regWrt <= ctrl.regWrt;
            memRead <= ctrl.memRead;
            memWrt <= ctrl.memWrt;
            immSrc <= ctrl.immSrc;
            bSrc <= ctrl.bSrc;
            regSrc <= ctrl.regSrc;
            aluSign <= ctrl.aluSign;
            aluJmp <= ctrl.aluJmp;
            branch <= ctrl.branch;
            oper <= aluCtrl.oper;
            invA <= aluCtrl.invA;
            invB <= aluCtrl.invB;
            cin <= aluCtrl.cin;
            rsData <= regPort.read1Data;
            rtData <= regPort.read2Data;
            imm5 <= imm5Ext;
            imm8 <= imm8Ext;
            sImm8 <= sImm8Ext;
            sImm11 <= sImm11Ext;
            pcNext <= pc;
            rd <= dstSel;
            halt <= haltDec;
            err <= errDec;
        end
    end

    memAccessExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(memRead && memWrt)
    ) else $error("memRead and memWrt both high");

    // An illegal opcode never reaches writeback
    errBlocksWrite: assert property (
        @(posedge clk) disable iff (reset)
        err |-> !regWrt ##(WbLatency-1) !regPort.writeEn
    ) else $error("illegal opcode produced a register write");

endmodule

/* decodeStageTb.sv */
// Decode stage testbench with random instructions checked against a reference model
module decodeStageTb
    import decodePkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WbLatency = 3;
    localparam int ClkPeriod = 100;
    localparam int DriveDelay = 10;
    localparam int ResetCycles = 2;
    localparam int NumSweep = 8;
    localparam int NumRandom = 400;
    localparam int TimeoutNs = (ResetCycles + NumSweep + NumRandom + 20) * ClkPeriod;

    logic                   clk;
    logic                   reset;
    logic [15:0]            instr;
    logic [DataWidth-1:0]   pc;
    logic [DataWidth-1:0]   wbData;
    logic                   regWrt;
    logic                   memRead;
    logic                   memWrt;
    logic                   immSrc;
    logic [1:0]             bSrc;
    logic [1:0]             regSrc;
    logic                   aluSign;
    logic                   aluJmp;
    logic [3:0]             branch;
    logic [3:0]             oper;
    logic                   invA;
    logic                   invB;
    logic                   cin;
    logic [DataWidth-1:0]   rsData;
    logic [DataWidth-1:0]   rtData;
    logic [DataWidth-1:0]   imm5;
    logic [DataWidth-1:0]   imm8;
    logic [DataWidth-1:0]   sImm8;
    logic [DataWidth-1:0]   sImm11;
    logic [DataWidth-1:0]   pcNext;
    logic [RegSelWidth-1:0] rd;
    logic                   halt;
    logic                   err;

    // Reference model state
    logic [DataWidth-1:0]   modelRegs [8];
    logic [3:0]             pendQ [$];
    ctrlWordT               expCtrl;
    aluCtrlT                expAlu;
    logic [DataWidth-1:0]   expRs;
    logic [DataWidth-1:0]   expRt;
    logic [DataWidth-1:0]   expImm5;
    logic [DataWidth-1:0]   expImm8;
    logic [DataWidth-1:0]   expSImm8;
    logic [DataWidth-1:0]   expSImm11;
    logic [DataWidth-1:0]   expPc;
    logic [RegSelWidth-1:0] expRd;
    logic                   expHalt;
    logic                   expErr;
    logic                   hasExp;
    int                     errorCount;

    decodeStage #(
        .WbLatency (WbLatency)
    ) decodeStage_i (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired: the run did not complete within %0d ns", TimeoutNs);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic checkCtrl(input string name, input ctrlWordT got, input ctrlWordT exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
            errorCount++;
        end
    endtask

    task automatic checkAlu(input string name, input aluCtrlT got, input aluCtrlT exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
            errorCount++;
        end
    endtask

    task automatic checkData(input string name, input logic [DataWidth-1:0] got,
                             input logic [DataWidth-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
            errorCount++;
        end
    endtask

    function automatic logic isLegal(input logic [4:0] op);
        return op inside {HALT, NOP, J, JAL, ADDI, SUBI, XORI, ANDNI,
                          BEQZ, BNEZ, ST, LD, LBI, RTYPE, SEQ};
    endfunction

    // Roughly one illegal opcode in eight
    function automatic logic [4:0] randomOpcode();
        logic [4:0] op;
        logic       wantLegal;
        wantLegal = ($urandom_range(7) != 0);
        do begin
            op = 5'($urandom);
        end while (isLegal(op) != wantLegal);
        return op;
    endfunction

    function automatic ctrlWordT decodeModel(input logic [4:0] op);
        ctrlWordT c;
        c = '0;
        case (op)
            J, JAL: begin
                c.aluJmp = 1'b1;
                c.immSrc = 1'b1;
                c.bSrc = BSRC_SIMM11;
                c.branch = BR_JMP;
                if (op == JAL) begin
                    c.regWrt = 1'b1;
                    c.regDst = LINK;
                    c.regSrc = RSRC_LINK;
                end
            end
            ADDI, SUBI, XORI, ANDNI: begin
                c.regWrt = 1'b1;
                c.immSrc = 1'b1;
                c.bSrc = BSRC_IMM5;
                c.zeroExt = (op == XORI) || (op == ANDNI);
                c.aluSign = !c.zeroExt;
                c.aluClass = (op == ADDI) ? ADD_I : (op == SUBI) ? SUB_I :
                             (op == XORI) ? XOR_I : ANDN_I;
            end
            BEQZ, BNEZ: begin
                c.bSrc = BSRC_IMM8;
                c.aluSign = 1'b1;
                c.aluClass = PASS_B;
                c.branch = (op == BEQZ) ? BR_EQZ : BR_NEZ;
            end
            ST, LD: begin
                c.memWrt = (op == ST);
                c.memRead = (op == LD);
                c.regWrt = (op == LD);
                c.immSrc = 1'b1;
                c.bSrc = BSRC_IMM5;
                c.regSrc = (op == LD) ? RSRC_MEM : RSRC_ALU;
            end
            LBI: begin
                c.regWrt = 1'b1;
                c.regDst = RS_FIELD;
                c.immSrc = 1'b1;
                c.bSrc = BSRC_IMM8;
                c.regSrc = RSRC_IMM;
                c.aluClass = PASS_B;
            end
            RTYPE, SEQ: begin
                c.regWrt = 1'b1;
                c.regDst = RTYPE_RD;
                c.aluSign = 1'b1;
                c.aluClass = (op == SEQ) ? CMP_EQ : FUNC;
            end
            default: begin
            end
        endcase
        return c;
    endfunction

    function automatic aluCtrlT aluModel(input aluClassT cls, input logic [1:0] func);
        aluCtrlT a;
        aluClassT eff;
        a = '0;
        eff = cls;
        if (cls == FUNC) begin
            eff = (func == 2'b00) ? ADD_I : (func == 2'b01) ? SUB_I :
                  (func == 2'b10) ? XOR_I : ANDN_I;
        end
        case (eff)
            ADD_I:  a.oper = ADD;
            SUB_I: begin
                a.oper = ADD;
                a.invA = 1'b1;
                a.cin = 1'b1;
            end
            XOR_I:  a.oper = XOR;
            ANDN_I: begin
                a.oper = ANDN;
                a.invB = 1'b1;
            end
            CMP_EQ: begin
                a.oper = EQ;
                a.invA = 1'b1;
                a.cin = 1'b1;
            end
            default: a.oper = PASSB;
        endcase
        return a;
    endfunction

    // Fields the DUT does not bring out are left zero
    function automatic ctrlWordT visibleCtrl(input ctrlWordT c);
        ctrlWordT v;
        v = c;
        v.regDst = ITYPE;
        v.zeroExt = 1'b0;
        v.aluClass = ADD_I;
        return v;
    endfunction

    // Register read with the write of the current cycle bypassed
    function automatic logic [DataWidth-1:0] readModel(input logic [2:0] sel,
            input logic [3:0] head, input logic [DataWidth-1:0] wb);
        if (head[3] && (head[2:0] == sel)) begin
            return wb;
        end
        return modelRegs[sel];
    endfunction

    task automatic checkOutputs();
        ctrlWordT gotCtrl;
        aluCtrlT  gotAlu;
        gotCtrl = '0;
        gotCtrl.regWrt = regWrt;
        gotCtrl.memRead = memRead;
        gotCtrl.memWrt = memWrt;
        gotCtrl.immSrc = immSrc;
        gotCtrl.bSrc = bSrcT'(bSrc);
        gotCtrl.regSrc = regSrcT'(regSrc);
        gotCtrl.aluSign = aluSign;
        gotCtrl.aluJmp = aluJmp;
        gotCtrl.branch = branchT'(branch);
        gotAlu.oper = aluOpT'(oper);
        gotAlu.invA = invA;
        gotAlu.invB = invB;
        gotAlu.cin = cin;
        checkCtrl("ctrl", gotCtrl, visibleCtrl(expCtrl));
        checkAlu("aluCtrl", gotAlu, expAlu);
        checkData("rsData", rsData, expRs);
        checkData("rtData", rtData, expRt);
        checkData("imm5", imm5, expImm5);
        checkData("imm8", imm8, expImm8);
        checkData("sImm8", sImm8, expSImm8);
        checkData("sImm11", sImm11, expSImm11);
        checkData("pcNext", pcNext, expPc);
        checkData("rd", 16'(rd), 16'(expRd));
        checkData("halt", 16'(halt), 16'(expHalt));
        checkData("err", 16'(err), 16'(expErr));
    endtask

    // Runs 10 ns after an edge and checks the previous instruction before driving the next
    task automatic issue(input logic [15:0] newInstr, input logic [DataWidth-1:0] newPc,
                         input logic [DataWidth-1:0] newWb);
        logic [3:0] head;
        ctrlWordT   c;
        if (hasExp) begin
            checkOutputs();
        end
        instr = newInstr;
        pc = newPc;
        wbData = newWb;

        head = pendQ.pop_front();
        c = decodeModel(newInstr[15:11]);
        expCtrl = c;
        expAlu = aluModel(c.aluClass, newInstr[1:0]);
        expRs = readModel(newInstr[10:8], head, newWb);
        expRt = readModel(newInstr[7:5], head, newWb);
        expImm5 = c.zeroExt ? {11'b0, newInstr[4:0]} : {{11{newInstr[4]}}, newInstr[4:0]};
        expSImm8 = {{8{newInstr[7]}}, newInstr[7:0]};
        expImm8 = c.zeroExt ? {8'b0, newInstr[7:0]} : expSImm8;
        expSImm11 = {{5{newInstr[10]}}, newInstr[10:0]};
        expPc = newPc;
        case (c.regDst)
            ITYPE:    expRd = newInstr[7:5];
            RTYPE_RD: expRd = newInstr[4:2];
            RS_FIELD: expRd = newInstr[10:8];
            default:  expRd = 3'd7;
        endcase
        expHalt = (newInstr[15:11] == HALT);
        expErr = !isLegal(newInstr[15:11]);

        // Commit this cycle's writeback before queueing this instruction's destination
        if (head[3]) begin
            modelRegs[head[2:0]] = newWb;
        end
        pendQ.push_back({c.regWrt, expRd});
        hasExp = 1'b1;

        @(posedge clk);
        #(DriveDelay);
    endtask

    initial begin
        reset = 1'b1;
        instr = {NOP, 11'h000};
        pc = '0;
        wbData = '0;
        errorCount = 0;
        hasExp = 1'b0;
        void'($urandom(32'h66b3));
        modelRegs = '{default: '0};
        repeat (WbLatency) pendQ.push_back(4'h0);

        repeat (ResetCycles) @(posedge clk);
        #(DriveDelay);

        // Everything cleared by reset
        expCtrl = '0;
        expAlu = '0;
        expRs = '0;
        expRt = '0;
        expImm5 = '0;
        expImm8 = '0;
        expSImm8 = '0;
        expSImm11 = '0;
        expPc = '0;
        expRd = '0;
        expHalt = 1'b0;
        expErr = 1'b0;
        checkOutputs();
        reset = 1'b0;

        // NOP sweep reads every register on both ports
        for (int i = 0; i < NumSweep; i++) begin
            issue({NOP, 3'(i), 3'(7 - i), 5'($urandom)}, 16'($urandom), 16'($urandom));
        end

        for (int i = 0; i < NumRandom; i++) begin
            issue({randomOpcode(), 11'($urandom)}, 16'($urandom), 16'($urandom));
        end
        checkOutputs();

        $display("Run complete: %0d instructions, %0d errors",
                 NumSweep + NumRandom, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
decodePkg.sv
regPortIf.sv
controlDecoder.sv
aluControl.sv
regFile.sv
decodeStage.sv
decodeStageTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = decodeStageTb
FILELIST = vlog.f
OBJDIR   = obj_dir
PASSMSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Output is echoed, then searched for the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
